// File: source/fetch_pkg.sv
// ########################################
// Fetch stage package
// Address, line and window types plus the
// segment to linear address helper
// ########################################

package fetch_pkg;

   // Linear address as seen by instruction memory
   typedef logic [31:0] addr_t;

   // Code segment register value
   typedef logic [15:0] seg_t;

   // One instruction memory line, 16 bytes, byte 0 in the low bits
   typedef logic [127:0] line_t;

   // Byte window handed to the decoder, 32 bytes
   typedef logic [255:0] window_t;

   // Valid bytes in the window, 0 to 32
   typedef logic [6:0] byte_cnt_t;

   // Bytes taken by the decoder in one transfer
   typedef logic [5:0] read_cnt_t;

   // Line geometry
   localparam int LINE_BYTES = 16;
   localparam int LINE_OFS_W = 4;

   // Real mode style translation, segment times 16 plus offset
   function automatic addr_t linear_addr(seg_t seg, addr_t ofs);
      addr_t seg_base;
      seg_base = {12'h000, seg, 4'h0};
      return seg_base + ofs;
   endfunction

   // Start of the line that holds the given address
   function automatic addr_t line_base(addr_t addr);
      return {addr[31:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
   endfunction

endpackage

// File: source/fetch_line_if.sv
// ########################################
// Line queue head interface
// Two head lines from queue to byte window
// ########################################

`timescale 1ns/100ps

interface fetch_line_if;

   // Head lines present, 0, 1 or 2
   logic [1:0]       lines_avail;

   // Oldest line and the one after it
   fetch_pkg::line_t head_line;
   fetch_pkg::line_t next_line;

   // Head line fully consumed
   logic             pop;

   modport queue_mp (
      output lines_avail,
      output head_line,
      output next_line,
      input  pop
   );

   modport window_mp (
      input  lines_avail,
      input  head_line,
      input  next_line,
      output pop
   );

endinterface

// File: source/fetch_addr_gen.sv
// ########################################
// Fetch address generation
// Issues aligned line requests and tracks
// in-flight and stale memory responses
// ########################################

`timescale 1ns/100ps

module fetch_addr_gen #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         arst_n_i,

   // Control
   input  logic                         flush_i,
   input  logic                         load_i,
   input  fetch_pkg::addr_t             load_addr_i,
   input  fetch_pkg::seg_t              cs_i,

   // Lines stored in the queue
   input  logic [$clog2(QUEUE_DEPTH):0] occupancy_i,

   // Memory request
   output logic                         imem_valid_o,
   input  logic                         imem_ready_i,
   output fetch_pkg::addr_t             imem_addr_o,

   // Memory response
   input  logic                         imem_rsp_valid_i,
   output logic                         rsp_push_o
);

   localparam int CNT_W  = $clog2(QUEUE_DEPTH) + 1;
   // Stale responses can pile up over back to back reloads
   localparam int DROP_W = CNT_W + 4;

   logic                fetch_en;
   logic [CNT_W-1:0]    inflight;
   logic [DROP_W-1:0]   drop_cnt;
   logic [CNT_W:0]      reserved;
   fetch_pkg::addr_t    req_addr;
   fetch_pkg::addr_t    lin_addr;
   logic                req_fire;
   logic                dropping;
   logic                restart;

   assign lin_addr = fetch_pkg::linear_addr(cs_i, load_addr_i);
   assign restart  = flush_i || load_i;

   // Queue slots already taken or promised to a pending response
   assign reserved = occupancy_i + inflight;

   assign imem_valid_o = fetch_en && (reserved < (CNT_W+1)'(QUEUE_DEPTH));
   assign imem_addr_o  = req_addr;
   assign req_fire     = imem_valid_o && imem_ready_i;

   // Responses are in order, so the stale ones come first
   assign dropping   = (drop_cnt != '0);
   assign rsp_push_o = imem_rsp_valid_i && !dropping;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fetch_en <= 1'b0;
         inflight <= '0;
         drop_cnt <= '0;
      end else begin
         if (load_i) begin
            fetch_en <= 1'b1;
         end else if (flush_i) begin
            fetch_en <= 1'b0;
         end

         if (restart) begin
            // All requests still out at memory turn stale,
            // including one accepted on this very edge
            drop_cnt <= drop_cnt + DROP_W'(inflight) + DROP_W'(req_fire)
                        - DROP_W'(imem_rsp_valid_i);
            inflight <= '0;
         end else begin
            drop_cnt <= drop_cnt - DROP_W'(imem_rsp_valid_i && dropping);
            inflight <= inflight + CNT_W'(req_fire) - CNT_W'(rsp_push_o);
         end
      end
   end

   // Next line to request
   always_ff @(posedge clk) begin
      if (load_i) begin
         req_addr <= fetch_pkg::line_base(lin_addr);
      end else if (req_fire) begin
         req_addr <= req_addr + fetch_pkg::addr_t'(fetch_pkg::LINE_BYTES);
      end
   end

endmodule

// File: source/fetch_line_queue.sv
// ########################################
// Instruction line queue
// FIFO of returned lines, shows two heads
// ########################################

`timescale 1ns/100ps

module fetch_line_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         arst_n_i,

   // Control
   input  logic                         flush_i,
   input  logic                         load_i,

   // Kept memory responses
   input  logic                         rsp_push_i,
   input  fetch_pkg::line_t             rsp_data_i,

   // Lines stored
   output logic [$clog2(QUEUE_DEPTH):0] occupancy_o,

   // Head lines towards the byte window
   fetch_line_if.queue_mp               lines
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   fetch_pkg::line_t   mem [QUEUE_DEPTH];
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   next_ptr;
   logic [CNT_W-1:0]   count;
   logic               clear;
   logic               push;
   logic               pop;

   assign clear = flush_i || load_i;

   // Space was reserved when the request went out, so no full check
   assign push = rsp_push_i && !clear;
   assign pop  = lines.pop && !clear;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else if (clear) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   // Line storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= rsp_data_i;
      end
   end

   // Pointer wraps with the power of two depth
   assign next_ptr = rd_ptr + 1'b1;

   assign lines.head_line = mem[rd_ptr];
   assign lines.next_line = mem[next_ptr];

   // Only the two oldest lines matter to the window
   assign lines.lines_avail = (count >= CNT_W'(2)) ? 2'd2 : count[1:0];

   assign occupancy_o = count;

endmodule

// File: source/fetch_byte_window.sv
// ########################################
// Fetch byte window
// Aligns 32 bytes from the fetch pointer
// and tracks the linear fetch address
// ########################################

`timescale 1ns/100ps

module fetch_byte_window (
   input  logic                  clk,
   input  logic                  arst_n_i,

   // Control
   input  logic                  flush_i,
   input  logic                  load_i,
   input  fetch_pkg::addr_t      load_addr_i,
   input  fetch_pkg::seg_t       cs_i,

   // Head lines from the queue
   fetch_line_if.window_mp       lines,

   // Pipestage
   output logic                  f_valid_o,
   input  logic                  f_ready_i,
   input  fetch_pkg::read_cnt_t  f_bytes_read_i,
   output fetch_pkg::byte_cnt_t  f_valid_bytes_o,
   output fetch_pkg::window_t    f_instr_o,
   output fetch_pkg::addr_t      f_pc_o
);

   localparam int LOW_W = fetch_pkg::LINE_OFS_W;

   logic [LOW_W-1:0]                        ptr;
   logic [$bits(fetch_pkg::read_cnt_t):0]   ptr_sum;
   fetch_pkg::addr_t                        pc;
   fetch_pkg::addr_t                        lin_addr;
   fetch_pkg::byte_cnt_t                    head_bytes;
   logic                                    advance;

   assign lin_addr = fetch_pkg::linear_addr(cs_i, load_addr_i);

   // Window is live as soon as the line with the fetch byte is in
   assign f_valid_o = (lines.lines_avail != 2'd0);

   // Two lines at most, so the count never exceeds 32
   assign head_bytes = fetch_pkg::byte_cnt_t'({lines.lines_avail, {LOW_W{1'b0}}});
   assign f_valid_bytes_o = f_valid_o ? head_bytes - fetch_pkg::byte_cnt_t'(ptr) : '0;

   // Byte ptr of the head line lands on window byte 0
   assign f_instr_o = {lines.next_line, lines.head_line} >> {ptr, 3'b000};

   assign f_pc_o = pc;

   // A restart on the same edge overrides the transfer
   assign advance = f_valid_o && f_ready_i && !flush_i && !load_i;
   assign ptr_sum = ptr + f_bytes_read_i;

   // Head line used up
   assign lines.pop = advance && (ptr_sum >= fetch_pkg::LINE_BYTES);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ptr <= '0;
         pc  <= '0;
      end else if (load_i) begin
         ptr <= lin_addr[LOW_W-1:0];
         pc  <= lin_addr;
      end else if (advance) begin
         // Low bits wrap into the following line
         ptr <= ptr_sum[LOW_W-1:0];
         pc  <= pc + fetch_pkg::addr_t'(f_bytes_read_i);
      end
   end

endmodule

// File: source/fetch_top.sv
// ########################################
// Fetch stage top level
// Address generation, line queue and
// byte window around instruction memory
// ########################################

`timescale 1ns/100ps

module fetch_top #(
   parameter int QUEUE_DEPTH = 4
) (
   // Clock and reset
   input  logic                  clk,
   input  logic                  arst_n_i,

   // Control
   input  logic                  flush_i,
   input  logic                  load_i,
   input  fetch_pkg::addr_t      load_addr_i,

   // Code segment
   input  fetch_pkg::seg_t       cs_i,

   // Instruction memory request
   output logic                  imem_valid_o,
   input  logic                  imem_ready_i,
   output fetch_pkg::addr_t      imem_addr_o,

   // Instruction memory response
   input  logic                  imem_rsp_valid_i,
   output logic                  imem_rsp_ready_o,
   input  fetch_pkg::line_t      imem_rsp_data_i,

   // Pipestage
   output logic                  f_valid_o,
   input  logic                  f_ready_i,
   input  fetch_pkg::read_cnt_t  f_bytes_read_i,
   output fetch_pkg::byte_cnt_t  f_valid_bytes_o,
   output fetch_pkg::window_t    f_instr_o,
   output fetch_pkg::addr_t      f_pc_o
);

   logic [$clog2(QUEUE_DEPTH):0] occupancy;
   logic                         rsp_push;

   fetch_line_if lines_if ();

   // Queue space is reserved at request time
   assign imem_rsp_ready_o = 1'b1;

   fetch_addr_gen #(
      .QUEUE_DEPTH      (QUEUE_DEPTH)
   ) u_addr_gen (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .flush_i          (flush_i),
      .load_i           (load_i),
      .load_addr_i      (load_addr_i),
      .cs_i             (cs_i),
      .occupancy_i      (occupancy),
      .imem_valid_o     (imem_valid_o),
      .imem_ready_i     (imem_ready_i),
      .imem_addr_o      (imem_addr_o),
      .imem_rsp_valid_i (imem_rsp_valid_i),
      .rsp_push_o       (rsp_push)
   );

   fetch_line_queue #(
      .QUEUE_DEPTH      (QUEUE_DEPTH)
   ) u_line_queue (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .flush_i          (flush_i),
      .load_i           (load_i),
      .rsp_push_i       (rsp_push),
      .rsp_data_i       (imem_rsp_data_i),
      .occupancy_o      (occupancy),
      .lines            (lines_if)
   );

   fetch_byte_window u_byte_window (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .flush_i          (flush_i),
      .load_i           (load_i),
      .load_addr_i      (load_addr_i),
      .cs_i             (cs_i),
      .lines            (lines_if),
      .f_valid_o        (f_valid_o),
      .f_ready_i        (f_ready_i),
      .f_bytes_read_i   (f_bytes_read_i),
      .f_valid_bytes_o  (f_valid_bytes_o),
      .f_instr_o        (f_instr_o),
      .f_pc_o           (f_pc_o)
   );

endmodule

// File: sim/fetch_checker.sv
// ########################################
// Fetch stage protocol checker
// Memory request and pipestage handshakes
// ########################################

`timescale 1ns/100ps

module fetch_checker (
   input logic             clk,
   input logic             arst_n_i,
   input logic             flush_i,
   input logic             load_i,
   input logic             imem_valid_o,
   input logic             imem_ready_i,
   input fetch_pkg::addr_t imem_addr_o,
   input logic             f_valid_o,
   input logic             f_ready_i
);

   // Count of failed assertions
   int unsigned fail_cnt = 0;

   // Pending request waits for ready unless a restart drops it
   req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
      imem_valid_o && !imem_ready_i && !flush_i && !load_i |=> imem_valid_o)
      else begin
         $error("memory request withdrawn before it was accepted");
         fail_cnt++;
      end

   req_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
      imem_valid_o |-> (imem_addr_o[3:0] == 4'h0))
      else begin
         $error("memory request address not line aligned");
         fail_cnt++;
      end

   // Window is held under back-pressure
   window_held: assert property (@(posedge clk) disable iff (!arst_n_i)
      f_valid_o && !f_ready_i && !flush_i && !load_i |=> f_valid_o)
      else begin
         $error("f_valid_o dropped while f_ready_i was low");
         fail_cnt++;
      end

endmodule

bind fetch_top fetch_checker u_checker (.*);

// File: sim/fetch_tb.sv
// ########################################
// Fetch stage testbench
// Memory model, stimulus table and checks
// ########################################

`timescale 1ns/100ps

module fetch_tb;

   // Segment, load offset, consume steps, bytes per step, flush after the row
   typedef struct packed {
      logic [15:0] seg;
      logic [31:0] ofs;
      logic [7:0]  steps;
      logic [4:0]  step_bytes;
      logic        flush_after;
   } row_t;

   localparam int NUM_ROWS = 6;

   logic                 clk = 1'b0;
   logic                 arst_n_i = 1'b0;
   logic                 flush_i = 1'b0;
   logic                 load_i = 1'b0;
   fetch_pkg::addr_t     load_addr_i = '0;
   fetch_pkg::seg_t      cs_i = '0;
   logic                 imem_valid_o;
   logic                 imem_ready_i = 1'b0;
   fetch_pkg::addr_t     imem_addr_o;
   logic                 imem_rsp_valid_i = 1'b0;
   logic                 imem_rsp_ready_o;
   fetch_pkg::line_t     imem_rsp_data_i = '0;
   logic                 f_valid_o;
   logic                 f_ready_i = 1'b0;
   fetch_pkg::read_cnt_t f_bytes_read_i = '0;
   fetch_pkg::byte_cnt_t f_valid_bytes_o;
   fetch_pkg::window_t   f_instr_o;
   fetch_pkg::addr_t     f_pc_o;

   row_t                 rows [NUM_ROWS];
   fetch_pkg::addr_t     cur_start;
   fetch_pkg::addr_t     exp_pc;
   fetch_pkg::addr_t     exp_req;
   fetch_pkg::addr_t     req_addr;
   fetch_pkg::addr_t     pend_addr [$];
   longint               pend_due [$];
   longint               cycle_cnt = 0;
   longint               due;
   bit                   halted = 1'b1;
   bit                   req_seen = 1'b0;
   int                   limit = 0;
   int                   k;

   fetch_top #(.QUEUE_DEPTH(4)) uut (.*);

   always #4 clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "run stopped");
   endtask

   task automatic check_val(input string name, input logic [255:0] exp, input logic [255:0] got);
      assert (exp == got)
         else stop_run($sformatf("error: %s expected %0h got %0h", name, exp, got));
   endtask

   // Memory content, low byte of the address plus the address shifted by eight
   function automatic logic [7:0] byte_at(fetch_pkg::addr_t a);
      fetch_pkg::addr_t sum;
      sum = a + (a >> 8);
      return sum[7:0];
   endfunction

   function automatic fetch_pkg::line_t line_at(fetch_pkg::addr_t base);
      fetch_pkg::line_t data;
      for (int i = 0; i < 16; i++) data[8*i +: 8] = byte_at(base + i);
      return data;
   endfunction

   // Memory with random ready and 1 to 5 cycles of in-order latency
   always @(posedge clk) begin
      if (arst_n_i) begin
         cycle_cnt++;
         if (req_seen) begin
            due = cycle_cnt + 1 + ($urandom % 5);
            if (pend_due.size() > 0 && due < pend_due[$]) due = pend_due[$];
            pend_addr.push_back(req_addr);
            pend_due.push_back(due);
         end
         imem_ready_i <= ($urandom % 3) != 0;
         if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
            imem_rsp_valid_i <= 1'b1;
            imem_rsp_data_i  <= line_at(pend_addr.pop_front());
            void'(pend_due.pop_front());
         end else begin
            imem_rsp_valid_i <= 1'b0;
         end
      end
   end

   // Outputs are settled at the falling edge
   always @(negedge clk) begin
      req_seen = arst_n_i && imem_valid_o && imem_ready_i;
      req_addr = imem_addr_o;
      if (arst_n_i) begin
         // Responses are never back-pressured
         check_val("imem_rsp_ready_o", 256'h1, imem_rsp_ready_o);
         if (halted) begin
            check_val("imem_valid_o", 256'h0, imem_valid_o);
            check_val("f_valid_o", 256'h0, f_valid_o);
         end
         if (req_seen) begin
            check_val("imem_addr_o", exp_req, imem_addr_o);
            exp_req = exp_req + 16;
         end
         if (f_valid_o) begin
            check_val("f_pc_o", exp_pc, f_pc_o);
            // Window always ends on a line boundary
            assert (f_valid_bytes_o != 0 && f_valid_bytes_o <= 32
                    && ((exp_pc + f_valid_bytes_o) % 16) == 0)
               else stop_run($sformatf("error: f_valid_bytes_o out of range, got %0h",
                                       f_valid_bytes_o));
            for (k = 0; k < f_valid_bytes_o; k++) begin
               check_val($sformatf("f_instr_o byte %0d", k), byte_at(exp_pc + k),
                         f_instr_o[8*k +: 8]);
            end
            if (f_ready_i && !flush_i && !load_i) exp_pc = exp_pc + f_bytes_read_i;
         end
         assert (uut.u_checker.fail_cnt == 0)
            else stop_run("a protocol assertion on the fetch stage failed");
         if (load_i) begin
            exp_pc  = cur_start;
            exp_req = {cur_start[31:4], 4'h0};
            halted  = 1'b0;
         end else if (flush_i) begin
            halted = 1'b1;
         end
      end
   end

   // One load, then single-cycle consume pulses once enough bytes are shown
   task automatic run_row(input int r);
      int done;
      @(posedge clk);
      cur_start   = 32'(rows[r].seg) * 16 + rows[r].ofs;
      cs_i        <= rows[r].seg;
      load_addr_i <= rows[r].ofs;
      load_i      <= 1'b1;
      @(posedge clk);
      load_i <= 1'b0;
      done = 0;
      while (done < rows[r].steps) begin
         @(negedge clk);
         if (f_valid_o && f_valid_bytes_o >= rows[r].step_bytes && $urandom % 4 != 0) begin
            @(posedge clk);
            f_ready_i      <= 1'b1;
            f_bytes_read_i <= fetch_pkg::read_cnt_t'(rows[r].step_bytes);
            @(posedge clk);
            f_ready_i <= 1'b0;
            done++;
         end else begin
            @(posedge clk);
         end
      end
      if (rows[r].flush_after) begin
         flush_i <= 1'b1;
         @(posedge clk);
         flush_i <= 1'b0;
         repeat (12) @(posedge clk);
      end
   endtask

   initial begin
      void'($urandom(32'hfd7));
      rows[0] = '{16'h1000, 32'h0000_0123, 8'd24, 5'd3, 1'b0};
      rows[1] = '{16'hf000, 32'h0000_fff7, 8'd30, 5'd7, 1'b1};
      rows[2] = '{16'h0040, 32'h0000_000f, 8'd16, 5'd16, 1'b0};
      rows[3] = '{16'h1234, 32'h0000_5678, 8'd40, 5'd1, 1'b1};
      rows[4] = '{16'h0000, 32'h0000_0000, 8'd20, 5'd13, 1'b0};
      rows[5] = '{16'hbeef, 32'h0000_0a05, 8'd25, 5'd5, 1'b0};
      repeat (3) @(posedge clk);
      arst_n_i <= 1'b1;
      repeat (8) @(posedge clk);
      for (int r = 0; r < NUM_ROWS; r++) run_row(r);
      repeat (16) @(posedge clk);
      if (uut.u_checker.fail_cnt == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         stop_run("a protocol assertion on the fetch stage failed");
      end
   end

   // Watchdog, 200 cycles for every consume step
   initial begin
      @(posedge arst_n_i);
      for (int r = 0; r < NUM_ROWS; r++) limit += 200 * rows[r].steps;
      repeat (limit) @(posedge clk);
      stop_run("timeout, the fetch stage stopped making progress");
   end

endmodule

// File: all.f
source/fetch_pkg.sv
source/fetch_line_if.sv
source/fetch_addr_gen.sv
source/fetch_line_queue.sv
source/fetch_byte_window.sv
source/fetch_top.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - source/fetch_pkg.sv
  - source/fetch_line_if.sv
  - source/fetch_addr_gen.sv
  - source/fetch_line_queue.sv
  - source/fetch_byte_window.sv
  - source/fetch_top.sv
  - target: simulation
    files:
      - sim/fetch_checker.sv
      - sim/fetch_tb.sv
